/* csr_settings.svh */
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

`define CSR_ADDR_W 14
`define CSR_DATA_W 32

// csr address map
`define CSR_ADDR_CRMD   14'h000
`define CSR_ADDR_PRMD   14'h001
`define CSR_ADDR_ECTL   14'h004
`define CSR_ADDR_ESTAT  14'h005
`define CSR_ADDR_ERA    14'h006
`define CSR_ADDR_EENTRY 14'h00c
`define CSR_ADDR_SAVE0  14'h030
`define CSR_ADDR_SAVE1  14'h031
`define CSR_ADDR_SAVE2  14'h032
`define CSR_ADDR_SAVE3  14'h033
`define CSR_ADDR_TID    14'h040
`define CSR_ADDR_TCFG   14'h041
`define CSR_ADDR_TVAL   14'h042
`define CSR_ADDR_TICLR  14'h044

// interrupt and exception fields
`define HWI_W      8
`define INT_PEND_W 13
`define ECODE_W    6
`define ESUBCODE_W 9
`define TI_BIT     11

`endif

/* csr_pkg.sv */
`include "csr_settings.svh"

package csr_pkg;

    typedef logic [1:0] plv_t;

    // current mode word
    typedef struct packed {
        logic [22:0] reserved;
        logic [1:0]  datm;
        logic [1:0]  datf;
        logic        pg;
        logic        da;
        logic        ie;
        plv_t        plv;
    } crmd_t;

    // timer config word
    typedef struct packed {
        logic [29:0] initval;
        logic        periodic;
        logic        en;
    } tcfg_t;

    // write data seen either raw or through a register's fields
    typedef union packed {
        logic [`CSR_DATA_W-1:0] raw;
        crmd_t                  crmd;
        tcfg_t                  tcfg;
    } csr_word_u;

endpackage

/* csr_event_if.sv */
`include "csr_settings.svh"

interface csr_event_if;

    logic                   excp_flush;
    logic                   ertn_flush;
    logic [`ECODE_W-1:0]    ecode;
    logic [`ESUBCODE_W-1:0] esubcode;
    logic [`CSR_DATA_W-1:0] era_in;

    // mode registers only care about the flush pulses
    modport mode_side (input excp_flush, input ertn_flush);

    modport info_side (input excp_flush, input ecode, input esubcode, input era_in);

endinterface

/* csr_mode_regs.sv */
`include "csr_settings.svh"

module csr_mode_regs
    import csr_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    wr_en,
    input  logic [`CSR_ADDR_W-1:0]  waddr,
    input  csr_word_u               wdata,
    csr_event_if.mode_side          ev,
    output plv_t                    plv_out,
    output logic                    ie,
    output logic [`INT_PEND_W-1:0]  ectl_lie,
    output logic [`CSR_DATA_W-1:0]  crmd_q,
    output logic [`CSR_DATA_W-1:0]  prmd_q,
    output logic [`CSR_DATA_W-1:0]  ectl_q
);

    localparam crmd_t CRMD_RST = '{reserved: '0, datm: 2'b0, datf: 2'b0,
                                   pg: 1'b0, da: 1'b1, ie: 1'b0, plv: 2'b0};

    crmd_t                  crmd;
    plv_t                   pplv;
    logic                   pie;
    logic [`INT_PEND_W-1:0] lie;
    logic                   crmd_wen;
    logic                   prmd_wen;
    logic                   ectl_wen;

    assign crmd_wen = wr_en && (waddr == `CSR_ADDR_CRMD);
    assign prmd_wen = wr_en && (waddr == `CSR_ADDR_PRMD);
    assign ectl_wen = wr_en && (waddr == `CSR_ADDR_ECTL);

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd <= CRMD_RST;
            pplv <= 2'b0;
            pie  <= 1'b0;
        end else if (ev.excp_flush) begin
            // enter kernel mode, interrupts off
            pplv     <= crmd.plv;
            pie      <= crmd.ie;
            crmd.plv <= 2'b0;
            crmd.ie  <= 1'b0;
        end else if (ev.ertn_flush) begin
            crmd.plv <= pplv;
            crmd.ie  <= pie;
        end else begin
            if (crmd_wen) begin
                crmd.plv  <= wdata.crmd.plv;
                crmd.ie   <= wdata.crmd.ie;
                crmd.da   <= wdata.crmd.da;
                crmd.pg   <= wdata.crmd.pg;
                crmd.datf <= wdata.crmd.datf;
                crmd.datm <= wdata.crmd.datm;
            end
            if (prmd_wen) begin
                pplv <= wdata.raw[1:0];
                pie  <= wdata.raw[2];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lie <= '0;
        end else if (ectl_wen) begin
            lie <= wdata.raw[`INT_PEND_W-1:0];
        end
    end

    // plv as it will be after this edge
    assign plv_out = ev.excp_flush ? 2'b0 :
                     ev.ertn_flush ? pplv :
                     crmd_wen      ? wdata.crmd.plv :
                                     crmd.plv;

    assign ie       = crmd.ie;
    assign ectl_lie = lie;
    assign crmd_q   = crmd;
    assign prmd_q   = {29'b0, pie, pplv};
    assign ectl_q   = {{(`CSR_DATA_W-`INT_PEND_W){1'b0}}, lie};

    // pipeline never retires both in one cycle
    assert property (@(posedge clk) disable iff (reset) !(ev.excp_flush && ev.ertn_flush))
        else $error("excp_flush and ertn_flush asserted together");

endmodule

/* csr_exception_regs.sv */
`include "csr_settings.svh"

module csr_exception_regs
    import csr_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    wr_en,
    input  logic [`CSR_ADDR_W-1:0]  waddr,
    input  csr_word_u               wdata,
    csr_event_if.info_side          ev,
    input  logic [`HWI_W-1:0]       interrupt,
    input  logic                    ie,
    input  logic [`INT_PEND_W-1:0]  ectl_lie,
    input  logic                    ti_pending,
    output logic                    has_int,
    output logic [`CSR_DATA_W-1:0]  estat_q,
    output logic [`CSR_DATA_W-1:0]  era_q,
    output logic [`CSR_DATA_W-1:0]  eentry_q,
    output logic [`CSR_DATA_W-1:0]  era_out,
    output logic [`CSR_DATA_W-1:0]  eentry_out
);

    logic [1:0]             is_sw;
    logic [`HWI_W-1:0]      is_hw;
    logic [`ECODE_W-1:0]    ecode;
    logic [`ESUBCODE_W-1:0] esubcode;
    logic [`CSR_DATA_W-1:0] era;
    logic [25:0]            eentry_va;
    logic [`CSR_DATA_W-1:0] estat;

    always_ff @(posedge clk) begin
        if (reset) begin
            is_sw     <= 2'b0;
            is_hw     <= '0;
            ecode     <= '0;
            esubcode  <= '0;
            era       <= '0;
            eentry_va <= '0;
        end else begin
            // hw lines sampled every cycle
            is_hw <= interrupt;
            if (ev.excp_flush) begin
                ecode    <= ev.ecode;
                esubcode <= ev.esubcode;
                era      <= ev.era_in;
            end else if (wr_en) begin
                if (waddr == `CSR_ADDR_ESTAT) begin
                    is_sw <= wdata.raw[1:0];
                end
                if (waddr == `CSR_ADDR_ERA) begin
                    era <= wdata.raw;
                end
            end
            if (wr_en && waddr == `CSR_ADDR_EENTRY) begin
                eentry_va <= wdata.raw[31:6];
            end
        end
    end

    always_comb begin
        estat               = '0;
        estat[1:0]          = is_sw;
        estat[9:2]          = is_hw;
        estat[`TI_BIT]      = ti_pending;
        estat[21:16]        = ecode;
        estat[30:22]        = esubcode;
    end

    assign has_int    = ie && (|(estat[`INT_PEND_W-1:0] & ectl_lie));
    assign estat_q    = estat;
    assign era_q      = era;
    assign era_out    = era;
    assign eentry_q   = {eentry_va, 6'b0};
    assign eentry_out = {eentry_va, 6'b0};

endmodule

/* csr_timer.sv */
`include "csr_settings.svh"

module csr_timer
    import csr_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    wr_en,
    input  logic [`CSR_ADDR_W-1:0]  waddr,
    input  csr_word_u               wdata,
    output logic                    ti_pending,
    output logic [`CSR_DATA_W-1:0]  tid_q,
    output logic [`CSR_DATA_W-1:0]  tcfg_q,
    output logic [`CSR_DATA_W-1:0]  tval_q
);

    logic [`CSR_DATA_W-1:0] tid;
    tcfg_t                  tcfg;
    logic [`CSR_DATA_W-1:0] tval;
    logic                   timer_en;
    logic                   tid_wen;
    logic                   tcfg_wen;
    logic                   ticlr_wen;
    logic                   expire;

    assign tid_wen   = wr_en && (waddr == `CSR_ADDR_TID);
    assign tcfg_wen  = wr_en && (waddr == `CSR_ADDR_TCFG);
    assign ticlr_wen = wr_en && (waddr == `CSR_ADDR_TICLR);
    assign expire    = timer_en && (tval == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            tid <= '0;
        end else if (tid_wen) begin
            tid <= wdata.raw;
        end
    end

    // config and countdown
    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg     <= '0;
            tval     <= '0;
            timer_en <= 1'b0;
        end else if (tcfg_wen) begin
            tcfg     <= wdata.tcfg;
            timer_en <= wdata.tcfg.en;
            tval     <= {wdata.tcfg.initval, 2'b00};
        end else if (expire) begin
            // reload or park at all ones
            tval     <= tcfg.periodic ? {tcfg.initval, 2'b00} : '1;
            timer_en <= tcfg.periodic;
        end else if (timer_en) begin
            tval <= tval - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ti_pending <= 1'b0;
        end else if (ticlr_wen && wdata.raw[0]) begin
            ti_pending <= 1'b0;
        end else if (expire && !tcfg_wen) begin
            ti_pending <= 1'b1;
        end
    end

    assign tid_q  = tid;
    assign tcfg_q = tcfg;
    assign tval_q = tval;

    // a stopped timer holds its count until reprogrammed
    assert property (@(posedge clk) disable iff (reset) !timer_en && !tcfg_wen |=> $stable(tval))
        else $error("tval moved while the timer was disabled");

endmodule

/* csr_readback.sv */
`include "csr_settings.svh"

module csr_readback
    import csr_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    wr_en,
    input  logic [`CSR_ADDR_W-1:0]  waddr,
    input  csr_word_u               wdata,
    input  logic [`CSR_ADDR_W-1:0]  raddr,
    input  logic [`CSR_DATA_W-1:0]  crmd_q,
    input  logic [`CSR_DATA_W-1:0]  prmd_q,
    input  logic [`CSR_DATA_W-1:0]  ectl_q,
    input  logic [`CSR_DATA_W-1:0]  estat_q,
    input  logic [`CSR_DATA_W-1:0]  era_q,
    input  logic [`CSR_DATA_W-1:0]  eentry_q,
    input  logic [`CSR_DATA_W-1:0]  tid_q,
    input  logic [`CSR_DATA_W-1:0]  tcfg_q,
    input  logic [`CSR_DATA_W-1:0]  tval_q,
    output logic [`CSR_DATA_W-1:0]  rdata
);

    logic [`CSR_DATA_W-1:0] save [4];
    logic [`CSR_DATA_W-1:0] sel;

    // scratch registers
    always_ff @(posedge clk) begin
        if (reset) begin
            save <= '{default: '0};
        end else if (wr_en) begin
            case (waddr)
                `CSR_ADDR_SAVE0: save[0] <= wdata.raw;
                `CSR_ADDR_SAVE1: save[1] <= wdata.raw;
                `CSR_ADDR_SAVE2: save[2] <= wdata.raw;
                `CSR_ADDR_SAVE3: save[3] <= wdata.raw;
                default: ;
            endcase
        end
    end

    always_comb begin
        case (raddr)
            `CSR_ADDR_CRMD:   sel = crmd_q;
            `CSR_ADDR_PRMD:   sel = prmd_q;
            `CSR_ADDR_ECTL:   sel = ectl_q;
            `CSR_ADDR_ESTAT:  sel = estat_q;
            `CSR_ADDR_ERA:    sel = era_q;
            `CSR_ADDR_EENTRY: sel = eentry_q;
            `CSR_ADDR_SAVE0:  sel = save[0];
            `CSR_ADDR_SAVE1:  sel = save[1];
            `CSR_ADDR_SAVE2:  sel = save[2];
            `CSR_ADDR_SAVE3:  sel = save[3];
            `CSR_ADDR_TID:    sel = tid_q;
            `CSR_ADDR_TCFG:   sel = tcfg_q;
            `CSR_ADDR_TVAL:   sel = tval_q;
            // ticlr and holes read zero
            default:          sel = '0;
        endcase
        rdata = (wr_en && waddr == raddr) ? wdata.raw : sel;
    end

endmodule

/* csr_top.sv */
`include "csr_settings.svh"

module csr_top
    import csr_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`CSR_ADDR_W-1:0]  csr_raddr,
    output logic [`CSR_DATA_W-1:0]  csr_rdata,
    input  logic                    csr_wr_en,
    input  logic [`CSR_ADDR_W-1:0]  csr_waddr,
    input  logic [`CSR_DATA_W-1:0]  csr_wdata,
    input  logic                    excp_flush,
    input  logic                    ertn_flush,
    input  logic [`ECODE_W-1:0]     ecode_in,
    input  logic [`ESUBCODE_W-1:0]  esubcode_in,
    input  logic [`CSR_DATA_W-1:0]  era_in,
    input  logic [`HWI_W-1:0]       interrupt,
    output logic                    has_int,
    output logic [1:0]              plv_out,
    output logic [`CSR_DATA_W-1:0]  era_out,
    output logic [`CSR_DATA_W-1:0]  eentry_out
);

    csr_word_u              wdata;
    logic                   ie;
    logic [`INT_PEND_W-1:0] ectl_lie;
    logic                   ti_pending;
    logic [`CSR_DATA_W-1:0] crmd_q;
    logic [`CSR_DATA_W-1:0] prmd_q;
    logic [`CSR_DATA_W-1:0] ectl_q;
    logic [`CSR_DATA_W-1:0] estat_q;
    logic [`CSR_DATA_W-1:0] era_q;
    logic [`CSR_DATA_W-1:0] eentry_q;
    logic [`CSR_DATA_W-1:0] tid_q;
    logic [`CSR_DATA_W-1:0] tcfg_q;
    logic [`CSR_DATA_W-1:0] tval_q;

    csr_event_if ev ();

    assign wdata.raw     = csr_wdata;
    assign ev.excp_flush = excp_flush;
    assign ev.ertn_flush = ertn_flush;
    assign ev.ecode      = ecode_in;
    assign ev.esubcode   = esubcode_in;
    assign ev.era_in     = era_in;

    csr_mode_regs u_mode (
        .clk(clk), .reset(reset), .wr_en(csr_wr_en), .waddr(csr_waddr), .wdata(wdata),
        .ev(ev), .plv_out(plv_out), .ie(ie), .ectl_lie(ectl_lie),
        .crmd_q(crmd_q), .prmd_q(prmd_q), .ectl_q(ectl_q)
    );

    csr_exception_regs u_excp (
        .clk(clk), .reset(reset), .wr_en(csr_wr_en), .waddr(csr_waddr), .wdata(wdata),
        .ev(ev), .interrupt(interrupt), .ie(ie), .ectl_lie(ectl_lie),
        .ti_pending(ti_pending), .has_int(has_int), .estat_q(estat_q), .era_q(era_q),
        .eentry_q(eentry_q), .era_out(era_out), .eentry_out(eentry_out)
    );

    csr_timer u_timer (
        .clk(clk), .reset(reset), .wr_en(csr_wr_en), .waddr(csr_waddr), .wdata(wdata),
        .ti_pending(ti_pending), .tid_q(tid_q), .tcfg_q(tcfg_q), .tval_q(tval_q)
    );

    csr_readback u_readback (
        .clk(clk), .reset(reset), .wr_en(csr_wr_en), .waddr(csr_waddr), .wdata(wdata),
        .raddr(csr_raddr), .crmd_q(crmd_q), .prmd_q(prmd_q), .ectl_q(ectl_q),
        .estat_q(estat_q), .era_q(era_q), .eentry_q(eentry_q), .tid_q(tid_q),
        .tcfg_q(tcfg_q), .tval_q(tval_q), .rdata(csr_rdata)
    );

endmodule

/* tb_csr_checker.sv */
`include "csr_settings.svh"

module tb_csr_checker (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`CSR_ADDR_W-1:0]  raddr,
    input  logic [`CSR_DATA_W-1:0]  rdata,
    input  logic                    wr_en,
    input  logic [`CSR_ADDR_W-1:0]  waddr,
    input  logic [`CSR_DATA_W-1:0]  wdata,
    input  logic                    excp_flush,
    input  logic                    ertn_flush,
    input  logic [`ECODE_W-1:0]     ecode,
    input  logic [`ESUBCODE_W-1:0]  esubcode,
    input  logic [`CSR_DATA_W-1:0]  era_in,
    input  logic [`HWI_W-1:0]       interrupt,
    input  logic                    has_int,
    input  logic [1:0]              plv_out,
    input  logic [`CSR_DATA_W-1:0]  era_out,
    input  logic [`CSR_DATA_W-1:0]  eentry_out,
    output int                      errors
);

    // shadow state, one field per architectural register
    logic [31:0] m_crmd;
    logic [31:0] m_prmd;
    logic [31:0] m_ectl;
    logic [31:0] m_era;
    logic [31:0] m_eentry;
    logic [31:0] m_tid;
    logic [31:0] m_tcfg;
    logic [31:0] m_tval;
    logic [31:0] m_save [4];
    logic [1:0]  m_sw;
    logic [7:0]  m_hw;
    logic [5:0]  m_ecode;
    logic [8:0]  m_esubcode;
    logic        m_ten;
    logic        m_ti;
    logic        expire;
    logic        tcfg_wr;
    int          err_count = 0;

    assign expire  = m_ten && (m_tval == 32'h0);
    assign tcfg_wr = wr_en && (waddr == `CSR_ADDR_TCFG);
    assign errors  = err_count;

    always @(posedge clk) begin
        if (reset) begin
            m_crmd     <= 32'h0000_0008;
            m_prmd     <= '0;
            m_ectl     <= '0;
            m_era      <= '0;
            m_eentry   <= '0;
            m_tid      <= '0;
            m_tcfg     <= '0;
            m_tval     <= '0;
            m_save     <= '{default: '0};
            m_sw       <= '0;
            m_hw       <= '0;
            m_ecode    <= '0;
            m_esubcode <= '0;
            m_ten      <= 1'b0;
            m_ti       <= 1'b0;
        end else begin
            m_hw <= interrupt;
            if (excp_flush) begin
                m_prmd      <= {29'b0, m_crmd[2:0]};
                m_crmd[2:0] <= 3'b0;
                m_ecode     <= ecode;
                m_esubcode  <= esubcode;
                m_era       <= era_in;
            end else if (ertn_flush) begin
                m_crmd[2:0] <= m_prmd[2:0];
            end else if (wr_en) begin
                case (waddr)
                    `CSR_ADDR_CRMD:  m_crmd <= wdata & 32'h0000_01ff;
                    `CSR_ADDR_PRMD:  m_prmd <= wdata & 32'h0000_0007;
                    `CSR_ADDR_ESTAT: m_sw   <= wdata[1:0];
                    `CSR_ADDR_ERA:   m_era  <= wdata;
                    default: ;
                endcase
            end
            if (wr_en) begin
                case (waddr)
                    `CSR_ADDR_ECTL:   m_ectl    <= {19'b0, wdata[12:0]};
                    `CSR_ADDR_EENTRY: m_eentry  <= {wdata[31:6], 6'b0};
                    `CSR_ADDR_SAVE0:  m_save[0] <= wdata;
                    `CSR_ADDR_SAVE1:  m_save[1] <= wdata;
                    `CSR_ADDR_SAVE2:  m_save[2] <= wdata;
                    `CSR_ADDR_SAVE3:  m_save[3] <= wdata;
                    `CSR_ADDR_TID:    m_tid     <= wdata;
                    default: ;
                endcase
            end
            // timer: reprogram, expire, or count down
            if (tcfg_wr) begin
                m_tcfg <= wdata;
                m_ten  <= wdata[0];
                m_tval <= {wdata[31:2], 2'b00};
            end else if (expire) begin
                m_tval <= m_tcfg[1] ? {m_tcfg[31:2], 2'b00} : 32'hffff_ffff;
                m_ten  <= m_tcfg[1];
            end else if (m_ten) begin
                m_tval <= m_tval - 32'd1;
            end
            if (wr_en && waddr == `CSR_ADDR_TICLR && wdata[0]) begin
                m_ti <= 1'b0;
            end else if (expire && !tcfg_wr) begin
                m_ti <= 1'b1;
            end
        end
    end

    function automatic logic [31:0] model_estat();
        logic [31:0] v;
        v        = '0;
        v[1:0]   = m_sw;
        v[9:2]   = m_hw;
        v[11]    = m_ti;
        v[21:16] = m_ecode;
        v[30:22] = m_esubcode;
        return v;
    endfunction

    // reference for the read port, bypass included
    function automatic logic [31:0] expected_rdata(input logic [`CSR_ADDR_W-1:0] addr);
        if (wr_en && waddr == addr) begin
            return wdata;
        end
        case (addr)
            `CSR_ADDR_CRMD:   return m_crmd;
            `CSR_ADDR_PRMD:   return m_prmd;
            `CSR_ADDR_ECTL:   return m_ectl;
            `CSR_ADDR_ESTAT:  return model_estat();
            `CSR_ADDR_ERA:    return m_era;
            `CSR_ADDR_EENTRY: return m_eentry;
            `CSR_ADDR_SAVE0:  return m_save[0];
            `CSR_ADDR_SAVE1:  return m_save[1];
            `CSR_ADDR_SAVE2:  return m_save[2];
            `CSR_ADDR_SAVE3:  return m_save[3];
            `CSR_ADDR_TID:    return m_tid;
            `CSR_ADDR_TCFG:   return m_tcfg;
            `CSR_ADDR_TVAL:   return m_tval;
            default:          return 32'h0;
        endcase
    endfunction

    function automatic logic [1:0] expected_plv();
        if (excp_flush) begin
            return 2'b00;
        end
        if (ertn_flush) begin
            return m_prmd[1:0];
        end
        if (wr_en && waddr == `CSR_ADDR_CRMD) begin
            return wdata[1:0];
        end
        return m_crmd[1:0];
    endfunction

    function automatic logic expected_has_int();
        logic [31:0] est;
        est = model_estat();
        return m_crmd[2] && (|(est[12:0] & m_ectl[12:0]));
    endfunction

    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
        if (got !== exp) begin
            err_count++;
            $display("ERR t=%0t %s exp=0x%08h got=0x%08h", $time, name, exp, got);
        end
    endtask

    // outputs are settled mid-cycle
    always @(negedge clk) begin
        if (!reset) begin
            compare_word($sformatf("csr_rdata[0x%03h]", raddr), expected_rdata(raddr), rdata);
            compare_word("plv_out", {30'b0, expected_plv()}, {30'b0, plv_out});
            compare_word("has_int", {31'b0, expected_has_int()}, {31'b0, has_int});
            compare_word("era_out", m_era, era_out);
            compare_word("eentry_out", m_eentry, eentry_out);
        end
    end

endmodule

/* tb_csr_top.sv */
`include "csr_settings.svh"

module tb_csr_top;

    logic                   clk = 1'b0;
    logic                   reset;
    logic [`CSR_ADDR_W-1:0] raddr;
    logic [`CSR_DATA_W-1:0] rdata;
    logic                   wr_en;
    logic [`CSR_ADDR_W-1:0] waddr;
    logic [`CSR_DATA_W-1:0] wdata;
    logic                   excp_flush;
    logic                   ertn_flush;
    logic [`ECODE_W-1:0]    ecode_in;
    logic [`ESUBCODE_W-1:0] esubcode_in;
    logic [`CSR_DATA_W-1:0] era_in;
    logic [`HWI_W-1:0]      interrupt;
    logic                   has_int;
    logic [1:0]             plv_out;
    logic [`CSR_DATA_W-1:0] era_out;
    logic [`CSR_DATA_W-1:0] eentry_out;

    int    chk_errors;
    int    tb_errors = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    errors_at_start;
    string test_name;

    logic [`CSR_ADDR_W-1:0] reset_addrs [13];
    logic [`CSR_ADDR_W-1:0] rw_addrs [9];

    always #4 clk = ~clk;

    csr_top u_csr_top (
        .clk(clk), .reset(reset), .csr_raddr(raddr), .csr_rdata(rdata),
        .csr_wr_en(wr_en), .csr_waddr(waddr), .csr_wdata(wdata),
        .excp_flush(excp_flush), .ertn_flush(ertn_flush), .ecode_in(ecode_in),
        .esubcode_in(esubcode_in), .era_in(era_in), .interrupt(interrupt),
        .has_int(has_int), .plv_out(plv_out), .era_out(era_out), .eentry_out(eentry_out)
    );

    tb_csr_checker u_checker (
        .clk(clk), .reset(reset), .raddr(raddr), .rdata(rdata), .wr_en(wr_en),
        .waddr(waddr), .wdata(wdata), .excp_flush(excp_flush), .ertn_flush(ertn_flush),
        .ecode(ecode_in), .esubcode(esubcode_in), .era_in(era_in), .interrupt(interrupt),
        .has_int(has_int), .plv_out(plv_out), .era_out(era_out), .eentry_out(eentry_out),
        .errors(chk_errors)
    );

    // inputs change just after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic csr_write(input logic [`CSR_ADDR_W-1:0] addr, input logic [31:0] data);
        wr_en = 1'b1;
        waddr = addr;
        wdata = data;
        raddr = addr;
        next_cycle();
        wr_en = 1'b0;
    endtask

    task automatic csr_read(input logic [`CSR_ADDR_W-1:0] addr, output logic [31:0] data);
        raddr = addr;
        @(negedge clk);
        data = rdata;
        next_cycle();
    endtask

    task automatic note_failure(input string msg);
        tb_errors++;
        $display("t=%0t %s", $time, msg);
    endtask

    task automatic wait_timer_bit(input int limit, output logic seen);
        logic [31:0] d;
        seen = 1'b0;
        for (int i = 0; i < limit && !seen; i++) begin
            csr_read(`CSR_ADDR_ESTAT, d);
            seen = d[`TI_BIT];
        end
    endtask

    task automatic test_begin(input string name);
        test_name = name;
        errors_at_start = chk_errors + tb_errors;
    endtask

    task automatic test_end();
        tests_run++;
        if (chk_errors + tb_errors > errors_at_start) begin
            tests_failed++;
            $display("test %s: failed", test_name);
        end else begin
            $display("test %s: passed", test_name);
        end
    endtask

    initial begin
        logic [31:0] d;
        logic [31:0] rnd;
        logic [29:0] iv;
        logic        seen;

        reset       = 1'b1;
        raddr       = `CSR_ADDR_CRMD;
        wr_en       = 1'b0;
        waddr       = '0;
        wdata       = '0;
        excp_flush  = 1'b0;
        ertn_flush  = 1'b0;
        ecode_in    = '0;
        esubcode_in = '0;
        era_in      = '0;
        interrupt   = '0;
        rnd         = $urandom(31);
        reset_addrs = '{`CSR_ADDR_CRMD, `CSR_ADDR_PRMD, `CSR_ADDR_ECTL, `CSR_ADDR_ESTAT,
                        `CSR_ADDR_ERA, `CSR_ADDR_EENTRY, `CSR_ADDR_SAVE0, `CSR_ADDR_SAVE1,
                        `CSR_ADDR_SAVE2, `CSR_ADDR_SAVE3, `CSR_ADDR_TID, `CSR_ADDR_TCFG,
                        `CSR_ADDR_TVAL};
        rw_addrs    = '{`CSR_ADDR_SAVE0, `CSR_ADDR_SAVE1, `CSR_ADDR_SAVE2, `CSR_ADDR_SAVE3,
                        `CSR_ADDR_ERA, `CSR_ADDR_EENTRY, `CSR_ADDR_ECTL, `CSR_ADDR_PRMD,
                        `CSR_ADDR_CRMD};

        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        test_begin("reset_values");
        foreach (reset_addrs[i]) begin
            csr_read(reset_addrs[i], d);
        end
        test_end();

        test_begin("write_read_bypass");
        foreach (rw_addrs[i]) begin
            rnd = $urandom;
            csr_write(rw_addrs[i], rnd);
            csr_read(rw_addrs[i], d);
        end
        test_end();

        test_begin("exception");
        csr_write(`CSR_ADDR_CRMD, 32'h0000_000f);
        rnd         = $urandom;
        ecode_in    = rnd[5:0];
        esubcode_in = rnd[14:6];
        era_in      = $urandom;
        excp_flush  = 1'b1;
        next_cycle();
        excp_flush = 1'b0;
        csr_read(`CSR_ADDR_PRMD, d);
        csr_read(`CSR_ADDR_ERA, d);
        csr_read(`CSR_ADDR_ESTAT, d);
        csr_read(`CSR_ADDR_CRMD, d);
        ertn_flush = 1'b1;
        next_cycle();
        ertn_flush = 1'b0;
        csr_read(`CSR_ADDR_CRMD, d);
        test_end();

        test_begin("oneshot_timer");
        rnd = $urandom;
        iv  = {27'b0, rnd[2:0]} + 30'd2;
        csr_write(`CSR_ADDR_TCFG, {iv, 2'b01});
        wait_timer_bit(100, seen);
        if (!seen) begin
            note_failure("one-shot timer never set ESTAT bit 11 within 100 cycles");
        end
        for (int i = 0; i < 4; i++) begin
            csr_read(`CSR_ADDR_TVAL, d);
        end
        csr_write(`CSR_ADDR_TICLR, 32'h1);
        csr_read(`CSR_ADDR_ESTAT, d);
        test_end();

        test_begin("interrupt");
        rnd       = $urandom;
        interrupt = rnd[7:0];
        next_cycle();
        csr_read(`CSR_ADDR_ESTAT, d);
        csr_write(`CSR_ADDR_ESTAT, 32'h3);
        for (int k = 0; k < 6; k++) begin
            rnd = $urandom;
            csr_write(`CSR_ADDR_ECTL, {19'b0, rnd[12:0]});
            csr_write(`CSR_ADDR_CRMD, {28'b0, 1'b1, rnd[16], 2'b00});
            csr_read(`CSR_ADDR_ESTAT, d);
        end
        // timer bit alone as the only pending source
        interrupt = '0;
        csr_write(`CSR_ADDR_ESTAT, 32'h0);
        csr_write(`CSR_ADDR_TCFG, {30'd1, 2'b01});
        wait_timer_bit(100, seen);
        if (!seen) begin
            note_failure("timer bit never set while checking has_int");
        end
        csr_write(`CSR_ADDR_ECTL, 32'h0000_0800);
        csr_write(`CSR_ADDR_CRMD, 32'h0000_000c);
        csr_read(`CSR_ADDR_ESTAT, d);
        csr_write(`CSR_ADDR_CRMD, 32'h0000_0008);
        csr_write(`CSR_ADDR_TICLR, 32'h1);
        csr_read(`CSR_ADDR_ESTAT, d);
        test_end();

        test_begin("periodic_timer");
        rnd = $urandom;
        iv  = {27'b0, rnd[2:0]} + 30'd2;
        csr_write(`CSR_ADDR_TCFG, {iv, 2'b11});
        wait_timer_bit(100, seen);
        if (!seen) begin
            note_failure("periodic timer never set ESTAT bit 11 the first time");
        end
        csr_write(`CSR_ADDR_TICLR, 32'h1);
        csr_read(`CSR_ADDR_ESTAT, d);
        wait_timer_bit(100, seen);
        if (!seen) begin
            note_failure("periodic timer did not set ESTAT bit 11 again after the clear");
        end
        for (int i = 0; i < 60; i++) begin
            csr_read(`CSR_ADDR_TVAL, d);
            if (d == 32'hffff_ffff) begin
                note_failure("TVAL reached all ones with the periodic timer running");
            end
        end
        csr_write(`CSR_ADDR_TCFG, 32'h0);
        csr_read(`CSR_ADDR_TVAL, d);
        test_end();

        $display("tests run %0d, failed %0d, value errors %0d, other failures %0d",
                 tests_run, tests_failed, chk_errors, tb_errors);
        if (tests_failed == 0 && chk_errors + tb_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+.
csr_pkg.sv
csr_event_if.sv
csr_mode_regs.sv
csr_exception_regs.sv
csr_timer.sv
csr_readback.sv
csr_top.sv
tb_csr_checker.sv
tb_csr_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_csr_top -f verilog.f -o tb_csr_top

output=$(./obj_dir/tb_csr_top || true)
echo "$output"

if echo "$output" | grep -q "RESULT: PASS"; then
    exit 0
fi
exit 1
